// ==== Bender.yml ====
package:
  name: lawn_scene

sources:
  - rtl/lawnPkg.sv
  - rtl/sunflowerSway.sv
  - rtl/zombieMarch.sv
  - rtl/sceneClassifier.sv
  - rtl/pixelFifo.sv
  - rtl/colorMapper.sv
  - rtl/lawnScene.sv
  - target: test
    files:
      - dv/lawnSceneTb.sv

// ==== all.f ====
rtl/lawnPkg.sv
rtl/sunflowerSway.sv
rtl/zombieMarch.sv
rtl/sceneClassifier.sv
rtl/pixelFifo.sv
rtl/colorMapper.sv
rtl/lawnScene.sv
dv/lawnSceneTb.sv

// ==== dv/lawnSceneTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lawnSceneTb;

	localparam int NumPixels = 400;
	localparam int StreamTimeout = 20000;
	localparam int GameOverCycle = lawnPkg::ZombieStartX * lawnPkg::MarchTickCycles;
	// Classifier register, four FIFO entries and the mapper register
	localparam int PipeSlots = 6;
	// Area covered by the head at every point of its swing
	localparam int CoreLeft = 261;
	localparam int CoreRight = 314;
	localparam int CoreTop = 283;
	localparam int CoreBottom = 288;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	lawnPkg::coordT hCount;
	lawnPkg::coordT vCount;
	logic bright;
	logic outValid;
	logic outReady;
	lawnPkg::rgbT rgb;
	logic gameOver;

	int errors;
	int cycleCount;
	int sent;
	int received;
	int waitCycles;
	logic [31:0] rnd;
	logic inTaken;
	lawnPkg::rgbT nextColor;
	bit nextAnyHead;
	lawnPkg::rgbT expColor[$];
	bit expAnyHead[$];

	lawnScene lawnScene_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.hCount(hCount),
		.vCount(vCount),
		.bright(bright),
		.outValid(outValid),
		.outReady(outReady),
		.rgb(rgb),
		.gameOver(gameOver)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// One of five pixel kinds, each with its expected colour
	task automatic pickPixel();
		int kind;
		rnd = xorshift(rnd);
		kind = rnd % 5;
		rnd = xorshift(rnd);
		bright = 1'b1;
		nextAnyHead = 1'b0;
		case (kind)
			0:
			begin
				hCount = rnd % 1024;
				vCount = (rnd >> 10) % 1024;
				bright = 1'b0;
				nextColor = lawnPkg::ColorBlack;
			end
			1:
			begin
				hCount = rnd % 640;
				vCount = (rnd >> 10) % (lawnPkg::GreyZoneEnd + 1);
				nextColor = lawnPkg::ColorGrey;
			end
			2:
			begin
				hCount = 500 + rnd % 140;
				vCount = lawnPkg::GreyZoneEnd + 1 + (rnd >> 10) % (480 - lawnPkg::GreyZoneEnd - 1);
				nextColor = lawnPkg::ColorGreen;
			end
			3:
			begin
				hCount = lawnPkg::FlowerHome + 10'd58;
				vCount = lawnPkg::FlowerBase + 10'd70;
				nextColor = lawnPkg::ColorStem;
			end
			default:
			begin
				hCount = CoreLeft + rnd % (CoreRight - CoreLeft + 1);
				vCount = CoreTop + (rnd >> 10) % (CoreBottom - CoreTop + 1);
				nextColor = lawnPkg::ColorBlack;
				nextAnyHead = 1'b1;
			end
		endcase
	endtask

	// A pending pixel holds until it is taken
	task automatic driveStream();
		if (inTaken || !inValid)
		begin
			rnd = xorshift(rnd);
			if (sent < NumPixels && rnd[1:0] != 2'b00)
			begin
				inValid = 1'b1;
				pickPixel();
			end
			else
				inValid = 1'b0;
		end
		rnd = xorshift(rnd);
		outReady = (rnd[4:3] != 2'b00);
	endtask

	task automatic checkOutput();
		lawnPkg::rgbT want;
		bit anyHead;
		received++;
		if (expColor.size() == 0)
		begin
			errors++;
			$display("Output transfer at %0t with no pixel pending", $time);
		end
		else
		begin
			want = expColor.pop_front();
			anyHead = expAnyHead.pop_front();
			if (anyHead)
			begin
				assert (rgb == lawnPkg::ColorBlack || rgb == lawnPkg::ColorOrange ||
					rgb == lawnPkg::ColorYellow)
				else
				begin
					errors++;
					$display("Fail t=%0t rgb got %h expected %h, %h or %h", $time, rgb,
						lawnPkg::ColorBlack, lawnPkg::ColorOrange, lawnPkg::ColorYellow);
				end
			end
			else
			begin
				assert (rgb == want)
				else
				begin
					errors++;
					$display("Fail t=%0t rgb got %h expected %h", $time, rgb, want);
				end
			end
		end
	endtask

	// Handshakes seen here complete at the next rising edge
	task automatic recordTransfers();
		int inFlight;
		inFlight = sent - received;
		// Input stalls only once every stage holds a pixel
		assert (inReady == (inFlight < PipeSlots))
		else
		begin
			errors++;
			$display("Fail t=%0t inReady got %b expected %b", $time, inReady,
				inFlight < PipeSlots);
		end
		if (outValid && outReady)
			checkOutput();
		inTaken = inValid && inReady;
		if (inTaken)
		begin
			expColor.push_back(nextColor);
			expAnyHead.push_back(nextAnyHead);
			sent++;
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
			cycleCount <= 0;
		else
			cycleCount <= cycleCount + 1;
	end

	always @(negedge clk)
	begin
		if (!reset)
			assert (gameOver == (cycleCount >= GameOverCycle))
			else
			begin
				errors++;
				$display("Fail t=%0t gameOver got %b expected %b", $time, gameOver,
					cycleCount >= GameOverCycle);
			end
	end

	assert property (@(posedge clk) disable iff (reset) gameOver |=> gameOver)
	else
	begin
		errors++;
		$display("gameOver fell at %0t without a reset", $time);
	end

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		hCount = '0;
		vCount = '0;
		bright = 1'b0;
		outReady = 1'b0;
		errors = 0;
		sent = 0;
		received = 0;
		inTaken = 1'b0;
		rnd = 32'hfbdd;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (!outValid && !gameOver)
		else
		begin
			errors++;
			$display("Output valid or game over set right after reset");
		end

		waitCycles = 0;
		while (received < NumPixels && waitCycles < StreamTimeout)
		begin
			@(negedge clk);
			waitCycles++;
			driveStream();
			#1;
			recordTransfers();
		end
		if (received < NumPixels)
		begin
			errors++;
			$display("Timed out with %0d of %0d pixels received", received, NumPixels);
		end

		// Keep watching the stream until game over has been checked
		waitCycles = 0;
		while (cycleCount < GameOverCycle + 16 && waitCycles < 2 * GameOverCycle)
		begin
			@(negedge clk);
			waitCycles++;
			driveStream();
			#1;
			recordTransfers();
		end
		if (cycleCount < GameOverCycle + 16)
		begin
			errors++;
			$display("Timed out waiting for the game over cycle");
		end
		if (expColor.size() != 0 || received != sent)
		begin
			errors++;
			$display("Pixels lost, %0d sent and %0d received", sent, received);
		end

		$display("Done with %0d errors, %0d pixels sent, %0d received", errors, sent, received);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/colorMapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module colorMapper (
	input wire clk,
	input wire reset,
	input wire fifoValid,
	output logic fifoReady,
	input wire lawnPkg::regionT fifoRegion,
	output logic outValid,
	input wire outReady,
	output lawnPkg::rgbT rgb
);

	lawnPkg::rgbT color;

	always_comb
	begin
		case (fifoRegion)
			lawnPkg::regionBlank: color = lawnPkg::ColorBlack;
			// Face features are drawn black on the disc
			lawnPkg::regionFace: color = lawnPkg::ColorBlack;
			lawnPkg::regionInner: color = lawnPkg::ColorOrange;
			lawnPkg::regionOuter: color = lawnPkg::ColorYellow;
			lawnPkg::regionStem: color = lawnPkg::ColorStem;
			lawnPkg::regionGrey: color = lawnPkg::ColorGrey;
			lawnPkg::regionLawn: color = lawnPkg::ColorGreen;
			default: color = lawnPkg::ColorBlack;
		endcase
	end

	assign fifoReady = !outValid || outReady;

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else if (fifoReady)
			outValid <= fifoValid;
	end

	always_ff @(posedge clk)
	begin
		if (fifoValid && fifoReady)
			rgb <= color;
	end

endmodule

`default_nettype wire

// ==== rtl/lawnPkg.sv ====
`default_nettype none

package lawnPkg;

	// Screen coordinate for both the column and the row counter
	typedef logic [9:0] coordT;

	// Four bits per channel with red in the top nibble
	typedef logic [11:0] rgbT;

	// Listed in drawing priority after blanking
	typedef enum logic [2:0] {
		regionBlank,
		regionFace,
		regionInner,
		regionOuter,
		regionStem,
		regionGrey,
		regionLawn
	} regionT;

	typedef enum logic {
		gamePlay,
		gameLost
	} gameStateT;

	localparam rgbT ColorBlack = 12'h000;
	localparam rgbT ColorGrey = 12'h888;
	localparam rgbT ColorGreen = 12'h0F0;
	localparam rgbT ColorYellow = 12'hFF0;
	localparam rgbT ColorOrange = 12'hFC0;
	localparam rgbT ColorStem = 12'h0B4;

	// Sky band covers rows 0 up to this one
	localparam coordT GreyZoneEnd = 10'd159;

	// Stem anchor, also the rest position of the head
	localparam coordT FlowerHome = 10'd225;
	localparam coordT FlowerBase = 10'd374;
	localparam coordT HeadSwing = 10'd30;

	localparam coordT ZombieStartX = 10'd300;
	localparam coordT LawnEdge = 10'd0;

	// Clock cycles per animation step
	localparam int SwayTickCycles = 8;
	localparam int MarchTickCycles = 4;

endpackage

`default_nettype wire

// ==== rtl/lawnScene.sv ====
`timescale 1ns/1ps
`default_nettype none

module lawnScene (
	input wire clk,
	input wire reset,
	input wire inValid,
	output logic inReady,
	input wire lawnPkg::coordT hCount,
	input wire lawnPkg::coordT vCount,
	input wire bright,
	output logic outValid,
	input wire outReady,
	output lawnPkg::rgbT rgb,
	output logic gameOver
);

	lawnPkg::coordT headH;
	lawnPkg::coordT headV;
	logic classValid;
	logic classReady;
	lawnPkg::regionT classRegion;
	logic fifoValid;
	logic fifoReady;
	lawnPkg::regionT fifoRegion;

	// Animation sources
	sunflowerSway sunflowerSway_i (
		.clk(clk),
		.reset(reset),
		.headH(headH),
		.headV(headV)
	);

	zombieMarch zombieMarch_i (
		.clk(clk),
		.reset(reset),
		.gameOver(gameOver)
	);

	// Pixel stream: classify, buffer, colour
	sceneClassifier sceneClassifier_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.hCount(hCount),
		.vCount(vCount),
		.bright(bright),
		.headH(headH),
		.headV(headV),
		.classValid(classValid),
		.classRegion(classRegion),
		.classReady(classReady)
	);

	pixelFifo #(
		.FifoDepth(4)
	) pixelFifo_i (
		.clk(clk),
		.reset(reset),
		.classValid(classValid),
		.classReady(classReady),
		.classRegion(classRegion),
		.fifoValid(fifoValid),
		.fifoReady(fifoReady),
		.fifoRegion(fifoRegion)
	);

	colorMapper colorMapper_i (
		.clk(clk),
		.reset(reset),
		.fifoValid(fifoValid),
		.fifoReady(fifoReady),
		.fifoRegion(fifoRegion),
		.outValid(outValid),
		.outReady(outReady),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== rtl/pixelFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelFifo #(
	parameter int FifoDepth = 4
) (
	input wire clk,
	input wire reset,
	input wire classValid,
	output logic classReady,
	input wire lawnPkg::regionT classRegion,
	output logic fifoValid,
	input wire fifoReady,
	output lawnPkg::regionT fifoRegion
);

	lawnPkg::regionT mem [FifoDepth];
	logic [$clog2(FifoDepth)-1:0] wrPtr;
	logic [$clog2(FifoDepth)-1:0] rdPtr;
	logic [$clog2(FifoDepth+1)-1:0] count;
	logic wrEn;
	logic rdEn;

	assign classReady = (count != FifoDepth);
	assign fifoValid = (count != 0);
	assign fifoRegion = mem[rdPtr];
	assign wrEn = classValid && classReady;
	assign rdEn = fifoValid && fifoReady;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap by hand so any depth works
			if (wrEn)
				wrPtr <= (wrPtr == FifoDepth - 1) ? '0 : wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= (rdPtr == FifoDepth - 1) ? '0 : rdPtr + 1'b1;

			case ({wrEn, rdEn})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= classRegion;
	end

	// Full never grows and empty never shrinks
	assert property (@(posedge clk) disable iff (reset)
		count == FifoDepth |=> count >= FifoDepth - 1);
	assert property (@(posedge clk) disable iff (reset)
		count == 0 |=> count <= 1);

endmodule

`default_nettype wire

// ==== rtl/sceneClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module sceneClassifier (
	input wire clk,
	input wire reset,
	input wire inValid,
	output logic inReady,
	input wire lawnPkg::coordT hCount,
	input wire lawnPkg::coordT vCount,
	input wire bright,
	input wire lawnPkg::coordT headH,
	input wire lawnPkg::coordT headV,
	output logic classValid,
	output lawnPkg::regionT classRegion,
	input wire classReady
);

	logic inFace;
	logic inInner;
	logic inOuter;
	logic inStem;
	logic inGrey;
	lawnPkg::regionT region;

	// Inclusive rectangle test
	function automatic logic inBox(
		input lawnPkg::coordT x,
		input lawnPkg::coordT y,
		input lawnPkg::coordT left,
		input lawnPkg::coordT right,
		input lawnPkg::coordT top,
		input lawnPkg::coordT bottom
	);
		return (x >= left) && (x <= right) && (y >= top) && (y <= bottom);
	endfunction

	// Two eyes, two mouth corners and the mouth bar
	assign inFace =
		inBox(hCount, vCount, headH + 10'd46, headH + 10'd54, headV - 10'd103, headV - 10'd90) ||
		inBox(hCount, vCount, headH + 10'd71, headH + 10'd79, headV - 10'd103, headV - 10'd90) ||
		inBox(hCount, vCount, headH + 10'd41, headH + 10'd49, headV - 10'd63, headV - 10'd53) ||
		inBox(hCount, vCount, headH + 10'd76, headH + 10'd84, headV - 10'd63, headV - 10'd53) ||
		inBox(hCount, vCount, headH + 10'd46, headH + 10'd79, headV - 10'd55, headV - 10'd43);

	assign inInner =
		inBox(hCount, vCount, headH + 10'd26, headH + 10'd99, headV - 10'd123, headV - 10'd25);

	// Petals in five bands, widest across the middle
	assign inOuter =
		inBox(hCount, vCount, headH + 10'd18, headH + 10'd107, headV - 10'd154, headV - 10'd122) ||
		inBox(hCount, vCount, headH + 10'd6, headH + 10'd119, headV - 10'd121, headV - 10'd86) ||
		inBox(hCount, vCount, headH, headH + 10'd125, headV - 10'd85, headV - 10'd68) ||
		inBox(hCount, vCount, headH + 10'd6, headH + 10'd119, headV - 10'd67, headV - 10'd32) ||
		inBox(hCount, vCount, headH + 10'd18, headH + 10'd107, headV - 10'd31, headV + 10'd14);

	// Shaft plus a leaf on each side at the foot
	assign inStem =
		inBox(hCount, vCount, lawnPkg::FlowerHome + 10'd55, lawnPkg::FlowerHome + 10'd71,
			lawnPkg::FlowerBase, lawnPkg::FlowerBase + 10'd96) ||
		inBox(hCount, vCount, lawnPkg::FlowerHome, lawnPkg::FlowerHome + 10'd54,
			lawnPkg::FlowerBase + 10'd86, lawnPkg::FlowerBase + 10'd96) ||
		inBox(hCount, vCount, lawnPkg::FlowerHome + 10'd72, lawnPkg::FlowerHome + 10'd124,
			lawnPkg::FlowerBase + 10'd86, lawnPkg::FlowerBase + 10'd96);

	assign inGrey = (vCount <= lawnPkg::GreyZoneEnd);

	always_comb
	begin
		if (!bright)
			region = lawnPkg::regionBlank;
		else if (inFace)
			region = lawnPkg::regionFace;
		else if (inInner)
			region = lawnPkg::regionInner;
		else if (inOuter)
			region = lawnPkg::regionOuter;
		else if (inStem)
			region = lawnPkg::regionStem;
		else if (inGrey)
			region = lawnPkg::regionGrey;
		else
			region = lawnPkg::regionLawn;
	end

	// Accept when empty or when the FIFO drains us this cycle
	assign inReady = !classValid || classReady;

	always_ff @(posedge clk)
	begin
		if (reset)
			classValid <= 1'b0;
		else if (inReady)
			classValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
			classRegion <= region;
	end

	// A stalled region holds until the FIFO takes it
	assert property (@(posedge clk) disable iff (reset)
		classValid && !classReady |=> classValid && $stable(classRegion));

endmodule

`default_nettype wire

// ==== rtl/sunflowerSway.sv ====
`timescale 1ns/1ps
`default_nettype none

module sunflowerSway (
	input wire clk,
	input wire reset,
	output lawnPkg::coordT headH,
	output lawnPkg::coordT headV
);

	logic [$clog2(lawnPkg::SwayTickCycles)-1:0] tickCount;
	logic tick;
	logic movingRight;
	logic movingAway;
	lawnPkg::coordT nextH;

	assign tick = (tickCount == lawnPkg::SwayTickCycles - 1);
	assign nextH = movingRight ? headH + 10'd1 : headH - 10'd1;

	// Stepping outward from the stem column counts as away
	assign movingAway = movingRight ? (headH >= lawnPkg::FlowerHome)
		: (headH <= lawnPkg::FlowerHome);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tickCount <= '0;
			movingRight <= 1'b1;
			headH <= lawnPkg::FlowerHome;
			headV <= lawnPkg::FlowerBase;
		end
		else
		begin
			if (tick)
				tickCount <= '0;
			else
				tickCount <= tickCount + 1'b1;

			if (tick)
			begin
				headH <= nextH;
				// Head droops on the way out and lifts on the way back
				if (movingAway)
					headV <= headV + 10'd1;
				else
					headV <= headV - 10'd1;

				if (nextH == lawnPkg::FlowerHome + lawnPkg::HeadSwing)
					movingRight <= 1'b0;
				else if (nextH == lawnPkg::FlowerHome - lawnPkg::HeadSwing)
					movingRight <= 1'b1;
			end
		end
	end

	// Head column stays inside the swing envelope for the whole run
	assert property (@(posedge clk) disable iff (reset)
		(headH >= lawnPkg::FlowerHome - lawnPkg::HeadSwing) &&
		(headH <= lawnPkg::FlowerHome + lawnPkg::HeadSwing));

endmodule

`default_nettype wire

// ==== rtl/zombieMarch.sv ====
`timescale 1ns/1ps
`default_nettype none

module zombieMarch (
	input wire clk,
	input wire reset,
	output logic gameOver
);

	logic [$clog2(lawnPkg::MarchTickCycles)-1:0] tickCount;
	logic tick;
	lawnPkg::coordT frontX;
	lawnPkg::gameStateT state;

	assign tick = (tickCount == lawnPkg::MarchTickCycles - 1);
	assign gameOver = (state == lawnPkg::gameLost);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tickCount <= '0;
			frontX <= lawnPkg::ZombieStartX;
			state <= lawnPkg::gamePlay;
		end
		else
		begin
			if (tick)
				tickCount <= '0;
			else
				tickCount <= tickCount + 1'b1;

			// Column only walks while the game is on
			if (tick && state == lawnPkg::gamePlay)
			begin
				frontX <= frontX - 10'd1;
				if (frontX - 10'd1 == lawnPkg::LawnEdge)
					state <= lawnPkg::gameLost;
			end
		end
	end

	// Lost is terminal and the front column stays frozen there
	assert property (@(posedge clk) disable iff (reset)
		state == lawnPkg::gameLost |=> state == lawnPkg::gameLost && $stable(frontX));

endmodule

`default_nettype wire
